//--- sim.f
hdl/rvseed_pkg.sv
hdl/mul.sv
hdl/alu.sv
hdl/ex_stage.sv
tb/tb_ex_stage.sv

//--- tb/ex_testdata.txt
# columns, all hex: op word ext src1 src2 expected_data expected_cond
# op and ext are the enum codes of alu_op_e and ext_e
00 0 0 0000000000000005 0000000000000007 000000000000000c 0
00 0 0 ffffffffffffffff 0000000000000001 0000000000000000 0
00 1 0 000000007fffffff 0000000000000001 ffffffff80000000 0
01 0 0 0000000000000003 0000000000000005 fffffffffffffffe 0
01 1 0 1234567800000000 0000000000000001 ffffffffffffffff 0
02 0 0 8000000000000000 0000000000000001 0000000000000001 0
03 0 0 8000000000000000 0000000000000001 0000000000000000 0
02 0 0 7fffffffffffffff 8000000000000000 0000000000000000 0
03 0 0 7fffffffffffffff 8000000000000000 0000000000000001 0
04 0 0 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 f000f000f000f000 0
05 0 0 f0f0f0f0f0f0f0f0 0f0f0f0f0f0f0f0f ffffffffffffffff 0
07 0 0 0000000000000001 0000000000000041 0000000000000002 0
07 0 0 0000000000000001 000000000000003f 8000000000000000 0
08 0 0 8000000000000000 00000000000000ff 0000000000000001 0
09 0 0 8000000000000000 0000000000000044 f800000000000000 0
09 0 0 f000000000000010 00000000000000c4 ff00000000000001 0
07 1 0 0000000000000001 000000000000003f ffffffff80000000 0
08 1 0 ffffffff80000000 0000000000000021 0000000040000000 0
09 1 0 0000000080000000 0000000000000024 fffffffff8000000 0
0a 0 0 0000000000000007 fffffffffffffffd ffffffffffffffeb 0
0a 0 0 fffffffffffffffe fffffffffffffffd 0000000000000006 0
0a 0 0 0000000100000001 0000000100000001 0000000200000001 0
0b 0 0 0000000000000064 0000000000000007 000000000000000e 0
0b 0 0 0000000000000064 0000000000000000 ffffffffffffffff 0
0c 0 0 0000000000000064 0000000000000007 0000000000000002 0
0c 0 0 0000000000000064 0000000000000000 0000000000000064 0
0d 1 1 00000000ffffff9c 0000000000000007 fffffffffffffff2 0
0e 1 1 00000000ffffff9c 0000000000000007 fffffffffffffffe 0
0d 1 1 0000000000000005 0000000000000000 ffffffffffffffff 0
0e 1 1 00000000fffffffb 0000000000000000 fffffffffffffffb 0
10 0 0 0000000000000005 0000000000000005 0000000000000000 1
10 0 0 0000000000000005 0000000000000003 0000000000000002 0
11 0 0 0000000000000005 0000000000000005 0000000000000000 0
11 0 0 0000000000000003 0000000000000005 fffffffffffffffe 1
12 0 0 ffffffffffffffff 0000000000000001 fffffffffffffffe 1
12 0 0 0000000000000005 0000000000000003 0000000000000002 0
13 0 0 0000000000000005 0000000000000005 0000000000000000 1
13 0 0 ffffffffffffffff 0000000000000001 fffffffffffffffe 0
14 0 0 ffffffffffffffff 0000000000000001 fffffffffffffffe 0
14 0 0 0000000000000003 0000000000000005 fffffffffffffffe 1
15 0 0 0000000000000005 0000000000000005 0000000000000000 1
15 0 0 0000000000000003 0000000000000005 fffffffffffffffe 0
0f 0 0 0000000000000000 0123456789ab8d80 0123456789ab8d80 0
0f 0 1 0000000000000000 0123456789ab8d80 ffffffff89ab8d80 0
0f 0 2 0000000000000000 0123456789ab8d80 0000000089ab8d80 0
0f 0 3 0000000000000000 0123456789ab8d80 ffffffffffff8d80 0
0f 0 4 0000000000000000 0123456789ab8d80 0000000000008d80 0
0f 0 5 0000000000000000 0123456789ab8d80 0000000000000080 0

//--- tb/tb_ex_stage.sv
`timescale 1ns/1ns

module tb_ex_stage import rvseed_pkg::*; ();

    localparam int timeout_cycles = 200;
    localparam int random_count   = 12;

    logic    clk;
    logic    reset;
    logic    issue;
    ex_req_t req;
    logic    busy;
    logic    res_valid;
    ex_res_t res;

    int     vec_num;
    integer seed;

    ex_stage i_dut (
        .clk       (clk),
        .reset     (reset),
        .issue     (issue),
        .req       (req),
        .busy      (busy),
        .res_valid (res_valid),
        .res       (res)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "run stopped at vector %0d", vec_num);
    endtask

    task automatic check(input string what, input logic [xlen-1:0] actual,
                         input logic [xlen-1:0] expected);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: vector %0d %s got %h expected %h",
                     $time, vec_num, what, actual, expected);
            abort_run();
        end
    endtask

    // issue one op, wait for the result and check it
    task automatic run_vector(input logic [op_width-1:0] op_code, input logic word,
                              input logic [ext_width-1:0] ext_code,
                              input logic [xlen-1:0] a, input logic [xlen-1:0] b,
                              input logic [xlen-1:0] exp_data, input logic exp_cond);
        int   waited;
        logic busy_ok;
        waited  = 0;
        busy_ok = 1'b1;
        @(posedge clk);
        issue    <= 1'b1;
        req.op   <= alu_op_e'(op_code);
        req.word <= word;
        req.ext  <= ext_e'(ext_code);
        req.src1 <= a;
        req.src2 <= b;
        @(posedge clk);  // dut takes the op here
        issue <= 1'b0;
        @(negedge clk);
        while (!res_valid && waited < timeout_cycles) begin
            if (!busy) begin
                busy_ok = 1'b0;
            end
            waited++;
            @(negedge clk);
        end
        if (!res_valid) begin
            $display("no result arrived for vector %0d within %0d cycles",
                     vec_num, timeout_cycles);
            abort_run();
        end else begin
            check("data", res.data, exp_data);
            check("cond", res.cond, exp_cond);
            check("busy while waiting", busy_ok, 1'b1);
            if (op_code != op_mul) begin
                check("latency", waited, 1);  // one cycle for single-cycle ops
            end
            @(negedge clk);
            check("res_valid pulse", res_valid, 1'b0);
            check("busy after result", busy, 1'b0);
            check("held data", res.data, exp_data);
        end
    endtask

    task automatic run_file_vectors();
        int                  fd;
        int                  n;
        logic                eof_seen;
        logic [8*128-1:0]    skip_buf;
        logic [7:0]          f_op;
        logic [3:0]          f_word;
        logic [3:0]          f_ext;
        logic [xlen-1:0]     f_a;
        logic [xlen-1:0]     f_b;
        logic [xlen-1:0]     f_data;
        logic [3:0]          f_cond;
        eof_seen = 1'b0;
        fd = $fopen("tb/ex_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/ex_testdata.txt");
            abort_run();
        end else begin
            while (!eof_seen) begin
                n = $fscanf(fd, " %h %h %h %h %h %h %h", f_op, f_word, f_ext,
                            f_a, f_b, f_data, f_cond);
                if (n == 7) begin
                    vec_num++;
                    run_vector(f_op[op_width-1:0], f_word[0], f_ext[ext_width-1:0],
                               f_a, f_b, f_data, f_cond[0]);
                end else if (n == 0) begin
                    n = $fgets(skip_buf, fd);  // comment line
                end else if (n < 0) begin
                    eof_seen = 1'b1;
                end else begin
                    $display("test data line after vector %0d has only %0d fields",
                             vec_num, n);
                    abort_run();
                end
            end
            $fclose(fd);
        end
    endtask

    // and, xor and add on random operands
    task automatic run_random_vectors();
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] expected;
        logic [wlen-1:0] sum_w;
        for (int i = 0; i < random_count; i++) begin
            a = {$random(seed), $random(seed)};
            b = {$random(seed), $random(seed)};
            vec_num++;
            case (i % 4)
                0: run_vector(op_and, 1'b0, ext_none, a, b, a & b, 1'b0);
                1: run_vector(op_xor, 1'b0, ext_none, a, b, a ^ b, 1'b0);
                2: run_vector(op_add, 1'b0, ext_none, a, b, a + b, 1'b0);
                default: begin
                    sum_w    = a[wlen-1:0] + b[wlen-1:0];
                    expected = {{(xlen-wlen){sum_w[wlen-1]}}, sum_w};  // addw
                    run_vector(op_add, 1'b1, ext_none, a, b, expected, 1'b0);
                end
            endcase
        end
    endtask

    initial begin
        reset       = 1'b1;
        issue       = 1'b0;
        req         = req_idle;
        vec_num     = 0;
        seed        = 14649;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        run_file_vectors();
        run_random_vectors();
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- hdl/ex_stage.sv
`timescale 1ns/1ns

module ex_stage import rvseed_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    issue,
    input  ex_req_t req,
    output logic    busy,
    output logic    res_valid,
    output ex_res_t res
);

    ex_req_t req_q;      // operation in flight
    logic    pending;
    logic    done;
    ex_res_t alu_res;
    logic    mul_stop;

    assign done = pending && !mul_stop;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_q     <= req_idle;
            pending   <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= 1'b0;
            if (!pending) begin
                if (issue) begin   // strobes while busy are dropped
                    req_q   <= req;
                    pending <= 1'b1;
                end
            end else if (!mul_stop) begin
                pending   <= 1'b0;
                res_valid <= 1'b1;
                // clear the op so a finished multiply sees mul_valid fall
                req_q     <= req_idle;
            end
        end
    end

    // result register, kept until the next completion
    always_ff @(posedge clk) begin
        if (done) begin
            res <= alu_res;
        end
    end

    assign busy = pending;

    alu i_alu (
        .clk      (clk),
        .reset    (reset),
        .req      (req_q),
        .res      (alu_res),
        .mul_stop (mul_stop)
    );

endmodule

//--- hdl/alu.sv
`timescale 1ns/1ns

module alu import rvseed_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  ex_req_t req,
    output ex_res_t res,
    output logic    mul_stop
);

    logic [xlen-1:0] raw;        // result before the extension step
    logic [xlen-1:0] ext_data;
    logic            cond;
    logic            mul_valid;
    logic [xlen-1:0] product;
    logic [5:0]      shamt;
    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic            w_ovf;
    logic [wlen-1:0] divw_q;
    logic [wlen-1:0] divw_r;

    function automatic logic [xlen-1:0] sext_w(input logic [wlen-1:0] v);
        return {{(xlen-wlen){v[wlen-1]}}, v};
    endfunction

    assign shamt = req.word ? {1'b0, req.src2[4:0]} : req.src2[5:0];

    // compare flags shared by slt and the branches
    assign eq   = (req.src1 == req.src2);
    assign lt_s = ($signed(req.src1) < $signed(req.src2));
    assign lt_u = (req.src1 < req.src2);

    assign mul_valid = (req.op == op_mul);

    // most negative word divided by -1
    assign w_ovf = (req.src1[wlen-1:0] == {1'b1, {(wlen-1){1'b0}}})
                   && (&req.src2[wlen-1:0]);

    // 32-bit divide, signed in word mode and unsigned otherwise
    always_comb begin
        if (req.src2[wlen-1:0] == '0) begin
            divw_q = '1;                     // x/0 gives all ones
            divw_r = req.src1[wlen-1:0];     // x%0 gives the dividend
        end else if (!req.word) begin
            divw_q = req.src1[wlen-1:0] / req.src2[wlen-1:0];
            divw_r = req.src1[wlen-1:0] % req.src2[wlen-1:0];
        end else if (w_ovf) begin
            divw_q = req.src1[wlen-1:0];
            divw_r = '0;
        end else begin
            divw_q = $signed(req.src1[wlen-1:0]) / $signed(req.src2[wlen-1:0]);
            divw_r = $signed(req.src1[wlen-1:0]) % $signed(req.src2[wlen-1:0]);
        end
    end

    always_comb begin
        raw  = req.src1 - req.src2;  // branches report the difference
        cond = 1'b0;
        case (req.op)
            op_add: begin
                raw = req.word ? sext_w(req.src1[wlen-1:0] + req.src2[wlen-1:0])
                               : req.src1 + req.src2;
            end
            op_sub: begin
                raw = req.word ? sext_w(req.src1[wlen-1:0] - req.src2[wlen-1:0])
                               : req.src1 - req.src2;
            end
            op_slt:  raw = {{(xlen-1){1'b0}}, lt_s};
            op_sltu: raw = {{(xlen-1){1'b0}}, lt_u};
            op_and:  raw = req.src1 & req.src2;
            op_or:   raw = req.src1 | req.src2;
            op_xor:  raw = req.src1 ^ req.src2;
            op_sll: begin
                raw = req.word ? sext_w(req.src1[wlen-1:0] << shamt)
                               : req.src1 << shamt;
            end
            op_srl: begin
                raw = req.word ? sext_w(req.src1[wlen-1:0] >> shamt)
                               : req.src1 >> shamt;
            end
            op_sra: begin
                // each form on its own keeps the shift signed
                if (req.word) begin
                    raw = sext_w($signed(req.src1[wlen-1:0]) >>> shamt);
                end else begin
                    raw = $signed(req.src1) >>> shamt;
                end
            end
            op_mul:  raw = product;  // final only once mul_stop drops
            op_divu: begin
                raw = (req.src2 == '0) ? '1 : req.src1 / req.src2;
            end
            op_remu: begin
                raw = (req.src2 == '0) ? req.src1 : req.src1 % req.src2;
            end
            op_divw: raw = sext_w(divw_q);
            op_remw: raw = sext_w(divw_r);
            op_pass: raw = req.src2;
            op_beq:  cond = eq;
            op_bne:  cond = !eq;
            op_blt:  cond = lt_s;
            op_bge:  cond = !lt_s;
            op_bltu: cond = lt_u;
            op_bgeu: cond = !lt_u;
            default: raw = req.src1 - req.src2;
        endcase
    end

    // trim or widen for loads and W results
    always_comb begin
        case (req.ext)
            ext_none:   ext_data = raw;
            ext_sext_w: ext_data = sext_w(raw[wlen-1:0]);
            ext_zext_w: ext_data = {{(xlen-wlen){1'b0}}, raw[wlen-1:0]};
            ext_sext_h: ext_data = {{(xlen-16){raw[15]}}, raw[15:0]};
            ext_zext_h: ext_data = {{(xlen-16){1'b0}}, raw[15:0]};
            ext_zext_b: ext_data = {{(xlen-8){1'b0}}, raw[7:0]};
            default:    ext_data = raw;
        endcase
    end

    assign res = '{data: ext_data, cond: cond};

    mul u_mul (
        .clk       (clk),
        .reset     (reset),
        .mul_valid (mul_valid),
        .src1      (req.src1),
        .src2      (req.src2),
        .product   (product),
        .stop      (mul_stop)
    );

endmodule

//--- hdl/mul.sv
`timescale 1ns/1ns

module mul import rvseed_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            mul_valid,
    input  logic [xlen-1:0] src1,
    input  logic [xlen-1:0] src2,     // held steady by the stage while busy
    output logic [xlen-1:0] product,
    output logic            stop
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_done
    } mul_state_e;

    mul_state_e      state;
    logic [6:0]      cnt;       // current bit of src2
    logic [xlen-1:0] mcand;     // src1 moved up one place per step
    logic [xlen-1:0] acc;       // low half of the running sum

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            cnt   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    cnt <= '0;
                    if (mul_valid) begin
                        state <= st_run;
                    end
                end
                st_run: begin
                    cnt <= cnt + 7'd1;
                    if (cnt == 7'd63) begin  // last partial product
                        state <= st_done;
                    end
                end
                st_done: begin
                    // rearm only once the op has gone away
                    if (!mul_valid) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // shift-add datapath, low 64 bits are the same for any signedness
    always_ff @(posedge clk) begin
        if (state == st_idle) begin
            acc   <= '0;
            mcand <= src1;
        end else if (state == st_run) begin
            if (src2[cnt[5:0]]) begin
                acc <= acc + mcand;
            end
            mcand <= mcand << 1;
        end
    end

    assign product = acc;
    assign stop    = mul_valid && (state != st_done);  // requested, not finished

endmodule

//--- hdl/rvseed_pkg.sv
package rvseed_pkg;

    localparam int xlen      = 64;
    localparam int wlen      = 32;  // width of the W forms
    localparam int op_width  = 5;
    localparam int ext_width = 3;

    typedef enum logic [op_width-1:0] {
        // arithmetic and logic
        op_add,
        op_sub,
        op_slt,
        op_sltu,
        op_and,
        op_or,
        op_xor,
        // shifts
        op_sll,
        op_srl,
        op_sra,
        // multiply and divide
        op_mul,
        op_divu,
        op_remu,
        op_divw,
        op_remw,
        op_pass,    // store data path, src2 straight through
        // branch conditions
        op_beq,
        op_bne,
        op_blt,
        op_bge,
        op_bltu,
        op_bgeu
    } alu_op_e;

    typedef enum logic [ext_width-1:0] {
        ext_none,
        ext_sext_w,
        ext_zext_w,
        ext_sext_h,
        ext_zext_h,
        ext_zext_b
    } ext_e;

    typedef struct packed {
        alu_op_e         op;
        logic            word;  // select the 32-bit form
        ext_e            ext;
        logic [xlen-1:0] src1;
        logic [xlen-1:0] src2;
    } ex_req_t;

    typedef struct packed {
        logic [xlen-1:0] data;
        logic            cond;  // branch taken
    } ex_res_t;

    // idle contents of the in-flight request
    localparam ex_req_t req_idle = '{op: op_add, word: 1'b0, ext: ext_none,
                                     src1: '0, src2: '0};

endpackage
